// File: include/mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// datapath widths
`define MS_XLEN   32
`define MS_RF_AW  5

// load kind code width
`define MS_OP_W   3

// load kinds carried in the execute record
`define MS_OP_NONE  3'd0
`define MS_OP_LD_B  3'd1
`define MS_OP_LD_BU 3'd2
`define MS_OP_LD_H  3'd3
`define MS_OP_LD_HU 3'd4
`define MS_OP_LD_W  3'd5

`endif

// File: hw/mem_stage_pkg.sv
`default_nettype none

`include "mem_stage_cfg.svh"

package mem_stage_pkg;

    typedef logic [`MS_XLEN-1:0]  word_t;
    typedef logic [`MS_RF_AW-1:0] rf_addr_t;
    typedef logic [`MS_OP_W-1:0]  mem_op_t;

    // load data buffer
    typedef enum logic [0:0] {
        BUF_EMPTY,
        BUF_FULL
    } buf_state_t;

    // 73-bit record from execute
    typedef struct packed {
        word_t    pc;
        mem_op_t  op;
        logic     rf_we;
        rf_addr_t rf_waddr;
        word_t    alu_result;
    } ex_to_mem_t;

    // 71-bit record to writeback
    // rf_wdata holds the bad address when ale is set
    typedef struct packed {
        word_t    pc;
        logic     rf_we;
        rf_addr_t rf_waddr;
        word_t    rf_wdata;
        logic     ale;
    } mem_to_wb_t;

    // 8-bit bypass record for decode
    typedef struct packed {
        logic     valid;
        logic     we;
        rf_addr_t waddr;
        logic     load_pending;
    } mem_fwd_t;

endpackage

`default_nettype wire

// File: hw/mem_pipe_reg.sv
`default_nettype none

module mem_pipe_reg (
    input  logic                       clk,
    input  logic                       resetn,

    // from execute
    input  logic                       es_to_ms_valid,
    input  mem_stage_pkg::ex_to_mem_t  es_to_ms_bus,

    // from merge logic and writeback
    input  logic                       ready_go,
    input  logic                       ws_allowin,
    input  logic                       except_flush,

    output logic                       ms_allowin,
    output logic                       ms_valid,
    output logic                       ms_to_ws_valid,
    output mem_stage_pkg::ex_to_mem_t  ms_payload
);

    logic take_in;

    // empty or current instruction can move on
    assign ms_allowin = !ms_valid || (ready_go && ws_allowin);

    assign take_in = es_to_ms_valid && ms_allowin;

    // flush hides the record in the same cycle
    assign ms_to_ws_valid = ms_valid && ready_go && !except_flush;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ms_valid <= 1'b0;
        end else if (except_flush) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
    end

    // payload only moves on a transfer
    always_ff @(posedge clk) begin
        if (take_in) begin
            ms_payload <= es_to_ms_bus;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_rdata_buf.sv
`default_nettype none

module mem_rdata_buf (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  ms_valid,
    input  logic                  leave,
    input  logic                  except_flush,
    input  logic                  data_sram_data_ok,
    input  mem_stage_pkg::word_t  data_sram_rdata,
    output logic                  have_data,
    output mem_stage_pkg::word_t  held_rdata
);

    mem_stage_pkg::buf_state_t state;
    mem_stage_pkg::buf_state_t state_nxt;
    mem_stage_pkg::word_t      rdata_q;
    logic                      capture;

    assign capture = (state == mem_stage_pkg::BUF_EMPTY) && ms_valid && data_sram_data_ok;

    always_comb begin
        state_nxt = state;
        // leaving wins over a same-cycle data_ok
        if (leave || except_flush) begin
            state_nxt = mem_stage_pkg::BUF_EMPTY;
        end else if (capture) begin
            state_nxt = mem_stage_pkg::BUF_FULL;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= mem_stage_pkg::BUF_EMPTY;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            rdata_q <= data_sram_rdata;
        end
    end

    assign have_data  = (state == mem_stage_pkg::BUF_FULL) || data_sram_data_ok;
    // live word on the strobe and stored copy after
    assign held_rdata = (state == mem_stage_pkg::BUF_FULL) ? rdata_q : data_sram_rdata;

endmodule

`default_nettype wire

// File: hw/mem_ale_check.sv
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_ale_check (
    input  mem_stage_pkg::mem_op_t  op,
    input  mem_stage_pkg::word_t    addr,
    output logic                    ale,
    output mem_stage_pkg::word_t    bad_addr
);

    logic is_half;
    logic is_word;
    logic half_mis;
    logic word_mis;

    assign is_half = (op == `MS_OP_LD_H) || (op == `MS_OP_LD_HU);
    assign is_word = (op == `MS_OP_LD_W);

    // halfword needs bit 0 clear
    assign half_mis = is_half && addr[0];

    // word needs both low bits clear
    assign word_mis = is_word && (addr[1:0] != 2'b00);

    // byte loads are always aligned
    assign ale = half_mis || word_mis;

    assign bad_addr = addr;

endmodule

`default_nettype wire

// File: hw/mem_result_merge.sv
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_result_merge (
    input  logic                       ms_valid,
    input  mem_stage_pkg::ex_to_mem_t  ms_payload,
    input  logic                       have_data,
    input  mem_stage_pkg::word_t       held_rdata,
    input  logic                       ale,
    input  mem_stage_pkg::word_t       bad_addr,
    output logic                       ready_go,
    output mem_stage_pkg::mem_to_wb_t  ms_to_ws_bus,
    output mem_stage_pkg::mem_fwd_t    ms_fwd
);

    logic                 is_load;
    logic                 is_signed;
    logic [1:0]           offset;
    logic [7:0]           byte_lane;
    logic [15:0]          half_lane;
    mem_stage_pkg::word_t load_data;
    mem_stage_pkg::word_t result;

    assign is_load   = (ms_payload.op != `MS_OP_NONE);
    assign is_signed = (ms_payload.op == `MS_OP_LD_B) || (ms_payload.op == `MS_OP_LD_H);
    assign offset    = ms_payload.alu_result[1:0];

    // a misaligned load never gets data_ok
    assign ready_go = !is_load || ale || have_data;

    always_comb begin
        case (offset)
            2'b00:   byte_lane = held_rdata[7:0];
            2'b01:   byte_lane = held_rdata[15:8];
            2'b10:   byte_lane = held_rdata[23:16];
            default: byte_lane = held_rdata[31:24];
        endcase
    end

    assign half_lane = offset[1] ? held_rdata[31:16] : held_rdata[15:0];

    always_comb begin
        case (ms_payload.op)
            `MS_OP_LD_B, `MS_OP_LD_BU: begin
                load_data = {{(`MS_XLEN-8){is_signed && byte_lane[7]}}, byte_lane};
            end
            `MS_OP_LD_H, `MS_OP_LD_HU: begin
                load_data = {{(`MS_XLEN-16){is_signed && half_lane[15]}}, half_lane};
            end
            default: begin
                load_data = held_rdata;
            end
        endcase
    end

    // exception reports the faulting address instead
    always_comb begin
        if (ale) begin
            result = bad_addr;
        end else if (is_load) begin
            result = load_data;
        end else begin
            result = ms_payload.alu_result;
        end
    end

    assign ms_to_ws_bus.pc       = ms_payload.pc;
    assign ms_to_ws_bus.rf_we    = ms_payload.rf_we && !ale;
    assign ms_to_ws_bus.rf_waddr = ms_payload.rf_waddr;
    assign ms_to_ws_bus.rf_wdata = result;
    assign ms_to_ws_bus.ale      = ale;

    // decode stalls while load_pending is up
    assign ms_fwd.valid        = ms_valid;
    assign ms_fwd.we           = ms_valid && ms_payload.rf_we && !ale;
    assign ms_fwd.waddr        = ms_payload.rf_waddr;
    assign ms_fwd.load_pending = ms_valid && is_load && !ale && !have_data;

endmodule

`default_nettype wire

// File: hw/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic                       clk,
    input  logic                       resetn,

    // execute side
    input  logic                       es_to_ms_valid,
    input  mem_stage_pkg::ex_to_mem_t  es_to_ms_bus,
    output logic                       ms_allowin,

    // writeback side
    input  logic                       ws_allowin,
    output logic                       ms_to_ws_valid,
    output mem_stage_pkg::mem_to_wb_t  ms_to_ws_bus,

    // data memory response
    input  logic                       data_sram_data_ok,
    input  mem_stage_pkg::word_t       data_sram_rdata,

    input  logic                       except_flush,

    // bypass to decode
    output mem_stage_pkg::mem_fwd_t    ms_fwd
);

    logic                       ms_valid;
    logic                       ready_go;
    logic                       leave;
    logic                       have_data;
    logic                       ale;
    mem_stage_pkg::ex_to_mem_t  ms_payload;
    mem_stage_pkg::word_t       held_rdata;
    mem_stage_pkg::word_t       bad_addr;

    assign leave = ms_to_ws_valid && ws_allowin;

    mem_pipe_reg u_pipe_reg (
        .clk            (clk),
        .resetn         (resetn),
        .es_to_ms_valid (es_to_ms_valid),
        .es_to_ms_bus   (es_to_ms_bus),
        .ready_go       (ready_go),
        .ws_allowin     (ws_allowin),
        .except_flush   (except_flush),
        .ms_allowin     (ms_allowin),
        .ms_valid       (ms_valid),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_payload     (ms_payload)
    );

    mem_rdata_buf u_rdata_buf (
        .clk               (clk),
        .resetn            (resetn),
        .ms_valid          (ms_valid),
        .leave             (leave),
        .except_flush      (except_flush),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .have_data         (have_data),
        .held_rdata        (held_rdata)
    );

    // the address is the alu result of the load
    mem_ale_check u_ale_check (
        .op       (ms_payload.op),
        .addr     (ms_payload.alu_result),
        .ale      (ale),
        .bad_addr (bad_addr)
    );

    mem_result_merge u_result_merge (
        .ms_valid     (ms_valid),
        .ms_payload   (ms_payload),
        .have_data    (have_data),
        .held_rdata   (held_rdata),
        .ale          (ale),
        .bad_addr     (bad_addr),
        .ready_go     (ready_go),
        .ms_to_ws_bus (ms_to_ws_bus),
        .ms_fwd       (ms_fwd)
    );

endmodule

`default_nettype wire

// File: testbench/tb_mem_stage.sv
`default_nettype none

`include "mem_stage_cfg.svh"

module tb_mem_stage;

    timeunit 1ns;
    timeprecision 1ps;

    // one table entry with stimulus and expected values
    typedef struct packed {
        mem_stage_pkg::mem_op_t  op;
        mem_stage_pkg::word_t    addr;
        mem_stage_pkg::word_t    mem_word;
        mem_stage_pkg::word_t    pc;
        mem_stage_pkg::rf_addr_t waddr;
        logic                    rf_we;
        int                      dly;
        int                      stall;
        logic                    flush;
        mem_stage_pkg::word_t    exp_wdata;
        logic                    exp_ale;
    } row_t;

    logic                      clk;
    logic                      resetn;
    logic                      es_to_ms_valid;
    mem_stage_pkg::ex_to_mem_t es_to_ms_bus;
    logic                      ws_allowin;
    logic                      data_sram_data_ok;
    mem_stage_pkg::word_t      data_sram_rdata;
    logic                      except_flush;
    logic                      ms_allowin;
    logic                      ms_to_ws_valid;
    mem_stage_pkg::mem_to_wb_t ms_to_ws_bus;
    mem_stage_pkg::mem_fwd_t   ms_fwd;

    row_t   rows[$];
    integer seed;
    int     cycles;
    int     limit;

    mem_stage DUT (
        .clk               (clk),
        .resetn            (resetn),
        .es_to_ms_valid    (es_to_ms_valid),
        .es_to_ms_bus      (es_to_ms_bus),
        .ms_allowin        (ms_allowin),
        .ws_allowin        (ws_allowin),
        .ms_to_ws_valid    (ms_to_ws_valid),
        .ms_to_ws_bus      (ms_to_ws_bus),
        .data_sram_data_ok (data_sram_data_ok),
        .data_sram_rdata   (data_sram_rdata),
        .except_flush      (except_flush),
        .ms_fwd            (ms_fwd)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("timeout: the run did not finish within %0d cycles", limit);
                $display("Regression failed");
                $fatal(1, "stopped on timeout");
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // loaded value as the load kind defines it
    function automatic mem_stage_pkg::word_t expect_load_data(
        input mem_stage_pkg::mem_op_t op,
        input mem_stage_pkg::word_t   addr,
        input mem_stage_pkg::word_t   word
    );
        mem_stage_pkg::word_t by_byte;
        mem_stage_pkg::word_t by_half;
        logic [7:0]           b;
        logic [15:0]          h;

        by_byte = word >> {addr[1:0], 3'b000};
        by_half = word >> {addr[1], 4'b0000};
        b = by_byte[7:0];
        h = by_half[15:0];
        case (op)
            `MS_OP_LD_B:  return {{24{b[7]}}, b};
            `MS_OP_LD_BU: return {24'd0, b};
            `MS_OP_LD_H:  return {{16{h[15]}}, h};
            `MS_OP_LD_HU: return {16'd0, h};
            `MS_OP_LD_W:  return word;
            default:      return addr;
        endcase
    endfunction

    function automatic logic misaligned_load(input mem_stage_pkg::mem_op_t op,
                                             input mem_stage_pkg::word_t addr);
        case (op)
            `MS_OP_LD_H, `MS_OP_LD_HU: return addr[0];
            `MS_OP_LD_W:               return addr[1] | addr[0];
            default:                   return 1'b0;
        endcase
    endfunction

    task automatic add_row(input mem_stage_pkg::mem_op_t op, input logic [1:0] off,
                           input int dly, input int stall, input logic flush);
        row_t   r;
        integer tmp;

        tmp        = $random(seed);
        r.op       = op;
        r.addr     = $random(seed);
        r.addr[1:0] = off;
        r.mem_word = $random(seed);
        r.pc       = $random(seed);
        r.pc[1:0]  = 2'b00;
        r.waddr    = tmp[4:0];
        r.rf_we    = (op != `MS_OP_NONE) || tmp[5];
        r.dly      = dly;
        r.stall    = stall;
        r.flush    = flush;
        r.exp_ale  = misaligned_load(op, r.addr);
        // bad address replaces the data on an exception
        r.exp_wdata = r.exp_ale ? r.addr : expect_load_data(op, r.addr, r.mem_word);
        rows.push_back(r);
    endtask

    task automatic build_table();
        // op, offset, data_ok delay, writeback stall, flush
        add_row(`MS_OP_NONE,  2'd0, 0, 0, 1'b0);
        add_row(`MS_OP_NONE,  2'd3, 0, 2, 1'b0);
        add_row(`MS_OP_LD_B,  2'd0, 0, 0, 1'b0);
        add_row(`MS_OP_LD_B,  2'd1, 1, 0, 1'b0);
        add_row(`MS_OP_LD_B,  2'd2, 2, 0, 1'b0);
        add_row(`MS_OP_LD_B,  2'd3, 3, 1, 1'b0);
        add_row(`MS_OP_LD_BU, 2'd0, 1, 0, 1'b0);
        add_row(`MS_OP_LD_BU, 2'd1, 0, 0, 1'b0);
        add_row(`MS_OP_LD_BU, 2'd2, 0, 2, 1'b0);
        add_row(`MS_OP_LD_BU, 2'd3, 2, 2, 1'b0);
        add_row(`MS_OP_LD_H,  2'd0, 0, 0, 1'b0);
        add_row(`MS_OP_LD_H,  2'd2, 3, 0, 1'b0);
        add_row(`MS_OP_LD_HU, 2'd0, 1, 0, 1'b0);
        add_row(`MS_OP_LD_HU, 2'd2, 0, 0, 1'b0);
        add_row(`MS_OP_LD_W,  2'd0, 0, 0, 1'b0);
        add_row(`MS_OP_LD_W,  2'd0, 2, 1, 1'b0);
        // misaligned rows never answered by memory
        add_row(`MS_OP_LD_H,  2'd1, 0, 0, 1'b0);
        add_row(`MS_OP_LD_H,  2'd3, 0, 2, 1'b0);
        add_row(`MS_OP_LD_HU, 2'd1, 0, 0, 1'b0);
        add_row(`MS_OP_LD_HU, 2'd3, 0, 1, 1'b0);
        add_row(`MS_OP_LD_W,  2'd1, 0, 0, 1'b0);
        add_row(`MS_OP_LD_W,  2'd2, 0, 1, 1'b0);
        add_row(`MS_OP_LD_W,  2'd3, 0, 0, 1'b0);
        // data arrives while writeback stalls
        add_row(`MS_OP_LD_W,  2'd0, 1, 4, 1'b0);
        add_row(`MS_OP_LD_B,  2'd3, 0, 3, 1'b0);
        add_row(`MS_OP_LD_HU, 2'd2, 2, 5, 1'b0);
        add_row(`MS_OP_LD_H,  2'd2, 0, 4, 1'b0);
        // each flush row followed by a normal row
        add_row(`MS_OP_LD_W,  2'd0, 3, 1, 1'b1);
        add_row(`MS_OP_NONE,  2'd0, 0, 0, 1'b0);
        add_row(`MS_OP_LD_H,  2'd2, 0, 2, 1'b1);
        add_row(`MS_OP_LD_B,  2'd1, 1, 0, 1'b0);
        add_row(`MS_OP_NONE,  2'd1, 0, 0, 1'b1);
        add_row(`MS_OP_LD_W,  2'd0, 0, 0, 1'b0);
        add_row(`MS_OP_LD_W,  2'd2, 0, 1, 1'b1);
        add_row(`MS_OP_LD_BU, 2'd3, 0, 0, 1'b0);
    endtask

    // called at a rising edge with the stage empty; returns at the leave or flush edge
    task automatic run_row(input row_t r);
        mem_stage_pkg::ex_to_mem_t bus;
        mem_stage_pkg::word_t      junk;
        int                        c;
        logic                      load_ok;
        logic                      ready;
        logic                      flush_now;
        logic                      wb_ready;
        logic                      done;

        bus.pc         = r.pc;
        bus.op         = r.op;
        bus.rf_we      = r.rf_we;
        bus.rf_waddr   = r.waddr;
        bus.alu_result = r.addr;
        load_ok = (r.op != `MS_OP_NONE) && !r.exp_ale;

        es_to_ms_valid    <= 1'b1;
        es_to_ms_bus      <= bus;
        ws_allowin        <= 1'b1;
        data_sram_data_ok <= 1'b0;
        except_flush      <= 1'b0;
        @(negedge clk);
        check_value("ms_allowin", 32'(ms_allowin), 32'd1);
        check_value("ms_to_ws_valid", 32'(ms_to_ws_valid), 32'd0);
        check_value("ms_fwd.valid", 32'(ms_fwd.valid), 32'd0);

        // after the transfer edge execute holds a scrambled record that must not get in
        @(posedge clk);
        es_to_ms_bus   <= ~bus;

        c    = 0;
        done = 1'b0;
        while (!done) begin
            flush_now = r.flush && (c == r.stall);
            wb_ready  = !r.flush && (c >= r.stall);
            ready     = !load_ok || (c >= r.dly);
            junk      = $random(seed);
            // execute waits with it whenever the stage should refuse
            es_to_ms_valid    <= !(ready && wb_ready);
            // memory responder strobes once for an aligned load
            data_sram_data_ok <= load_ok && (c == r.dly);
            data_sram_rdata   <= (c == r.dly) ? r.mem_word : junk;
            ws_allowin        <= wb_ready;
            except_flush      <= flush_now;
            @(negedge clk);
            check_value("ms_fwd.valid", 32'(ms_fwd.valid), 32'd1);
            check_value("ms_fwd.we", 32'(ms_fwd.we), 32'(r.rf_we && !r.exp_ale));
            check_value("ms_fwd.waddr", 32'(ms_fwd.waddr), 32'(r.waddr));
            check_value("ms_fwd.load_pending", 32'(ms_fwd.load_pending),
                        32'(load_ok && !ready));
            check_value("ms_to_ws_valid", 32'(ms_to_ws_valid), 32'(ready && !flush_now));
            check_value("ms_allowin", 32'(ms_allowin), 32'(ready && wb_ready));
            // contents must match on every valid cycle of a stall
            if (ms_to_ws_valid) begin
                check_value("ms_to_ws_bus.pc", ms_to_ws_bus.pc, r.pc);
                check_value("ms_to_ws_bus.rf_we", 32'(ms_to_ws_bus.rf_we),
                            32'(r.rf_we && !r.exp_ale));
                check_value("ms_to_ws_bus.rf_waddr", 32'(ms_to_ws_bus.rf_waddr),
                            32'(r.waddr));
                check_value("ms_to_ws_bus.rf_wdata", ms_to_ws_bus.rf_wdata, r.exp_wdata);
                check_value("ms_to_ws_bus.ale", 32'(ms_to_ws_bus.ale), 32'(r.exp_ale));
            end
            @(posedge clk);
            if (flush_now || (ready && wb_ready)) begin
                done = 1'b1;
            end
            c = c + 1;
        end
    endtask

    initial begin
        int max_dly;
        int max_stall;

        seed              = 32'h6511_af0d;
        max_dly           = 0;
        max_stall         = 0;
        limit             = 1000;
        resetn            = 1'b0;
        es_to_ms_valid    = 1'b0;
        es_to_ms_bus      = '0;
        ws_allowin        = 1'b1;
        data_sram_data_ok = 1'b0;
        data_sram_rdata   = '0;
        except_flush      = 1'b0;

        build_table();
        foreach (rows[i]) begin
            if (rows[i].dly > max_dly) begin
                max_dly = rows[i].dly;
            end
            if (rows[i].stall > max_stall) begin
                max_stall = rows[i].stall;
            end
        end
        // reset cycles on top of the per-row budget
        limit = rows.size() * (max_dly + max_stall + 4) + 8;

        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("ms_to_ws_valid", 32'(ms_to_ws_valid), 32'd0);
        check_value("ms_allowin", 32'(ms_allowin), 32'd1);
        check_value("ms_fwd.valid", 32'(ms_fwd.valid), 32'd0);
        @(posedge clk);
        resetn <= 1'b1;

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hw/mem_stage_pkg.sv
hw/mem_pipe_reg.sv
hw/mem_rdata_buf.sv
hw/mem_ale_check.sv
hw/mem_result_merge.sv
hw/mem_stage.sv
testbench/tb_mem_stage.sv

// File: Makefile
TOP := tb_mem_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f \
		--top-module $(TOP) -o $(TOP)

run: compile
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Regression failed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Regression passed" sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
